// File: nanorv_alu_stage.sv
// ALU stage: operand select, ALU, write request and registered write-back report
`timescale 1ns/1ps
`default_nettype none

`include "nanorv_consts.svh"

module nanorv_alu_stage (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  nanorv_pkg::ctrl_t           ctrl,
   input  wire logic [`NANORV_XLEN-1:0] imm,
   input  wire logic [`NANORV_XLEN-1:0] pc,
   input  wire logic [`NANORV_XLEN-1:0] rs1_data,
   input  wire logic [`NANORV_XLEN-1:0] rs2_data,
   input  wire logic                   illegal,
   output nanorv_pkg::wb_t             rf_wr,
   output nanorv_pkg::wb_t             wb,
   output logic                        illegal_instruction
);

   logic [`NANORV_XLEN-1:0]   port_a;
   logic [`NANORV_XLEN-1:0]   port_b;
   logic [`NANORV_REG_AW-1:0] shamt;
   logic [`NANORV_XLEN-1:0]   result;

   // ================================================
   // Operand selection
   // ================================================
   assign port_a = ctrl.use_pc  ? pc  : rs1_data;
   assign port_b = ctrl.use_imm ? imm : rs2_data;

   // Only the low 5 bits of B shift
   assign shamt = port_b[`NANORV_REG_AW-1:0];

   // ================================================
   // ALU
   // ================================================
   always_comb begin
      case (ctrl.alu_op)
         nanorv_pkg::ALU_ADD:    result = port_a + port_b;
         nanorv_pkg::ALU_SUB:    result = port_a - port_b;
         nanorv_pkg::ALU_SLL:    result = port_a << shamt;
         nanorv_pkg::ALU_SRL:    result = port_a >> shamt;
         nanorv_pkg::ALU_SRA:    result = $unsigned($signed(port_a) >>> shamt);
         nanorv_pkg::ALU_XOR:    result = port_a ^ port_b;
         nanorv_pkg::ALU_OR:     result = port_a | port_b;
         nanorv_pkg::ALU_AND:    result = port_a & port_b;
         nanorv_pkg::ALU_PASS_B: result = port_b;
         nanorv_pkg::ALU_SLT: begin
            result = {{(`NANORV_XLEN-1){1'b0}}, ($signed(port_a) < $signed(port_b))};
         end
         nanorv_pkg::ALU_SLTU: begin
            result = {{(`NANORV_XLEN-1){1'b0}}, (port_a < port_b)};
         end
         default:                result = port_b;
      endcase
   end

   // Same-cycle write request to the register file
   assign rf_wr = '{valid: ctrl.write_rd,
                    rd:    ctrl.rd,
                    data:  result};

   // ================================================
   // Write-back report, one cycle later
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb                  <= '0;
         illegal_instruction <= 1'b0;
      end else begin
         wb                  <= rf_wr;
         illegal_instruction <= illegal;
      end
   end

   // Decoder exclusivity must survive the register stage
   a_wb_not_illegal : assert property (@(posedge clk) disable iff (!rst_n)
      !(wb.valid && illegal_instruction))
      else $error("wb.valid and illegal_instruction high together");

endmodule

`default_nettype wire

// File: nanorv_consts.svh
// Data width, register count, opcode, funct3/funct7 and reset value macros
`ifndef NANORV_CONSTS_SVH
`define NANORV_CONSTS_SVH

// ================================================
// Widths
// ================================================
`define NANORV_XLEN      32
`define NANORV_NREGS     32
`define NANORV_REG_AW    5

// ================================================
// Major opcodes (RV32I)
// ================================================
`define NANORV_OPC_OP_IMM  7'b0010011
`define NANORV_OPC_OP      7'b0110011
`define NANORV_OPC_LUI     7'b0110111
`define NANORV_OPC_AUIPC   7'b0010111

// funct3 codes, shared by OP and OP-IMM
`define NANORV_F3_ADD    3'b000
`define NANORV_F3_SLL    3'b001
`define NANORV_F3_SLT    3'b010
`define NANORV_F3_SLTU   3'b011
`define NANORV_F3_XOR    3'b100
`define NANORV_F3_SR     3'b101
`define NANORV_F3_OR     3'b110
`define NANORV_F3_AND    3'b111

// funct7 values
`define NANORV_F7_BASE   7'b0000000
`define NANORV_F7_ALT    7'b0100000

// Register contents after reset
`define NANORV_REG_RESET 32'h0000_0000

`endif

// File: nanorv_core.f
+incdir+.
nanorv_pkg.sv
nanorv_regfile.sv
nanorv_decoder.sv
nanorv_alu_stage.sv
nanorv_core.sv
tb_nanorv_checker.sv
tb_nanorv_core.sv

// File: nanorv_core.sv
// Executor top: decoder, register file and ALU stage
`timescale 1ns/1ps
`default_nettype none

`include "nanorv_consts.svh"

module nanorv_core (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    inst_valid,
   input  wire logic [`NANORV_XLEN-1:0] inst,
   input  wire logic [`NANORV_XLEN-1:0] pc,
   output nanorv_pkg::wb_t              wb,
   output logic                         illegal_instruction
);

   nanorv_pkg::ctrl_t         ctrl;
   nanorv_pkg::wb_t           rf_wr;
   logic [`NANORV_XLEN-1:0]   imm;
   logic [`NANORV_REG_AW-1:0] rs1_idx;
   logic [`NANORV_REG_AW-1:0] rs2_idx;
   logic [`NANORV_XLEN-1:0]   rs1_data;
   logic [`NANORV_XLEN-1:0]   rs2_data;
   logic                      illegal;

   // ================================================
   // Decode and register read, in parallel
   // ================================================
   nanorv_decoder u_decoder (
      .inst       (nanorv_pkg::inst_u'(inst)),
      .inst_valid (inst_valid),
      .ctrl       (ctrl),
      .imm        (imm),
      .rs1_idx    (rs1_idx),
      .rs2_idx    (rs2_idx),
      .illegal    (illegal)
   );

   nanorv_regfile u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1_idx  (rs1_idx),
      .rs2_idx  (rs2_idx),
      .wr       (rf_wr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   // Execute and write back
   nanorv_alu_stage u_alu_stage (
      .clk                 (clk),
      .rst_n               (rst_n),
      .ctrl                (ctrl),
      .imm                 (imm),
      .pc                  (pc),
      .rs1_data            (rs1_data),
      .rs2_data            (rs2_data),
      .illegal             (illegal),
      .rf_wr               (rf_wr),
      .wb                  (wb),
      .illegal_instruction (illegal_instruction)
   );

endmodule

`default_nettype wire

// File: nanorv_decoder.sv
// Instruction decoder for the RV32I arithmetic subset, immediate rebuild and illegal flag
`timescale 1ns/1ps
`default_nettype none

`include "nanorv_consts.svh"

module nanorv_decoder (
   input  nanorv_pkg::inst_u              inst,
   input  wire logic                      inst_valid,
   output nanorv_pkg::ctrl_t              ctrl,
   output logic [`NANORV_XLEN-1:0]        imm,
   output logic [`NANORV_REG_AW-1:0]      rs1_idx,
   output logic [`NANORV_REG_AW-1:0]      rs2_idx,
   output logic                           illegal
);

   logic [`NANORV_XLEN-1:0] imm_i;
   logic [`NANORV_XLEN-1:0] imm_u;
   logic [`NANORV_XLEN-1:0] imm_shamt;
   logic [6:0]              funct7;
   logic [2:0]              funct3;
   logic                    f7_base;
   logic                    f7_alt;
   logic                    legal;
   logic                    use_imm;
   logic                    use_pc;
   nanorv_pkg::alu_op_e     op;

   assign funct7  = inst.r_fmt.funct7;
   assign funct3  = inst.r_fmt.funct3;
   assign f7_base = (funct7 == `NANORV_F7_BASE);
   assign f7_alt  = (funct7 == `NANORV_F7_ALT);

   // ================================================
   // Immediate reconstruction
   // ================================================
   assign imm_i = {{(`NANORV_XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};

   // U immediate is the upper 20 bits of the word
   assign imm_u = {inst.r_fmt.funct7, inst.r_fmt.rs2, inst.r_fmt.rs1,
                   inst.r_fmt.funct3, 12'b0};

   // Shift amount sits in the rs2 field
   assign imm_shamt = {{(`NANORV_XLEN-`NANORV_REG_AW){1'b0}}, inst.r_fmt.rs2};

   // ================================================
   // Opcode / funct decode
   // ================================================
   always_comb begin
      legal   = 1'b0;
      op      = nanorv_pkg::ALU_ADD;
      use_imm = 1'b0;
      use_pc  = 1'b0;
      imm     = imm_i;
      case (inst.r_fmt.opcode)
         `NANORV_OPC_OP_IMM: begin
            use_imm = 1'b1;
            legal   = 1'b1;
            case (funct3)
               `NANORV_F3_ADD:  op = nanorv_pkg::ALU_ADD;
               `NANORV_F3_SLT:  op = nanorv_pkg::ALU_SLT;
               `NANORV_F3_SLTU: op = nanorv_pkg::ALU_SLTU;
               `NANORV_F3_XOR:  op = nanorv_pkg::ALU_XOR;
               `NANORV_F3_OR:   op = nanorv_pkg::ALU_OR;
               `NANORV_F3_AND:  op = nanorv_pkg::ALU_AND;
               `NANORV_F3_SLL: begin
                  op    = nanorv_pkg::ALU_SLL;
                  imm   = imm_shamt;
                  legal = f7_base;
               end
               `NANORV_F3_SR: begin
                  // SRAI carries funct7 ALT in the upper imm bits
                  op    = f7_alt ? nanorv_pkg::ALU_SRA : nanorv_pkg::ALU_SRL;
                  imm   = imm_shamt;
                  legal = f7_base | f7_alt;
               end
               default: legal = 1'b0;
            endcase
         end
         `NANORV_OPC_OP: begin
            legal = f7_base;
            case (funct3)
               `NANORV_F3_ADD: begin
                  op    = f7_alt ? nanorv_pkg::ALU_SUB : nanorv_pkg::ALU_ADD;
                  legal = f7_base | f7_alt;
               end
               `NANORV_F3_SR: begin
                  op    = f7_alt ? nanorv_pkg::ALU_SRA : nanorv_pkg::ALU_SRL;
                  legal = f7_base | f7_alt;
               end
               `NANORV_F3_SLL:  op = nanorv_pkg::ALU_SLL;
               `NANORV_F3_SLT:  op = nanorv_pkg::ALU_SLT;
               `NANORV_F3_SLTU: op = nanorv_pkg::ALU_SLTU;
               `NANORV_F3_XOR:  op = nanorv_pkg::ALU_XOR;
               `NANORV_F3_OR:   op = nanorv_pkg::ALU_OR;
               `NANORV_F3_AND:  op = nanorv_pkg::ALU_AND;
               default:         legal = 1'b0;
            endcase
         end
         `NANORV_OPC_LUI: begin
            op      = nanorv_pkg::ALU_PASS_B;
            use_imm = 1'b1;
            imm     = imm_u;
            legal   = 1'b1;
         end
         `NANORV_OPC_AUIPC: begin
            op      = nanorv_pkg::ALU_ADD;
            use_imm = 1'b1;
            use_pc  = 1'b1;
            imm     = imm_u;
            legal   = 1'b1;
         end
         default: legal = 1'b0;
      endcase
   end

   // Register indices go straight to the register file
   assign rs1_idx = inst.r_fmt.rs1;
   assign rs2_idx = inst.r_fmt.rs2;

   assign ctrl = '{alu_op:   op,
                   use_imm:  use_imm,
                   use_pc:   use_pc,
                   write_rd: legal & inst_valid,
                   rd:       inst.r_fmt.rd};

   assign illegal = ~legal & inst_valid;

   // A valid word must be fully known
   always_comb begin
      a_inst_known : assert (!((inst_valid === 1'b1) && $isunknown(inst)))
         else $error("decoder received an unknown instruction word");
   end

endmodule

`default_nettype wire

// File: nanorv_pkg.sv
// Instruction union, ALU operation enum, control struct and write-back struct
`default_nettype none

`include "nanorv_consts.svh"

package nanorv_pkg;

   // ================================================
   // Instruction formats
   // ================================================

   // R format, also the source of the U immediate (upper 20 bits)
   typedef struct packed {
      logic [6:0]                 funct7;
      logic [`NANORV_REG_AW-1:0]  rs2;
      logic [`NANORV_REG_AW-1:0]  rs1;
      logic [2:0]                 funct3;
      logic [`NANORV_REG_AW-1:0]  rd;
      logic [6:0]                 opcode;
   } r_fmt_t;

   // I format
   typedef struct packed {
      logic [11:0]                imm12;
      logic [`NANORV_REG_AW-1:0]  rs1;
      logic [2:0]                 funct3;
      logic [`NANORV_REG_AW-1:0]  rd;
      logic [6:0]                 opcode;
   } i_fmt_t;

   // One instruction word, two views
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } inst_u;

   // ================================================
   // ALU operations
   // ================================================
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10
   } alu_op_e;

   // Decoded controls for the ALU stage
   typedef struct packed {
      alu_op_e                    alu_op;
      logic                       use_imm;  // Port B takes the immediate
      logic                       use_pc;   // Port A takes the PC
      logic                       write_rd;
      logic [`NANORV_REG_AW-1:0]  rd;
   } ctrl_t;

   // Write-back request / report
   typedef struct packed {
      logic                       valid;
      logic [`NANORV_REG_AW-1:0]  rd;
      logic [`NANORV_XLEN-1:0]    data;
   } wb_t;

endpackage

`default_nettype wire

// File: nanorv_regfile.sv
// 32x32 register file, two combinational read ports, one write port, x0 hardwired
`timescale 1ns/1ps
`default_nettype none

`include "nanorv_consts.svh"

module nanorv_regfile (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic [`NANORV_REG_AW-1:0] rs1_idx,
   input  wire logic [`NANORV_REG_AW-1:0] rs2_idx,
   input  nanorv_pkg::wb_t                wr,
   output logic [`NANORV_XLEN-1:0]        rs1_data,
   output logic [`NANORV_XLEN-1:0]        rs2_data
);

   // x1..x31 only, x0 has no storage
   logic [`NANORV_XLEN-1:0] regs [1:`NANORV_NREGS-1];

   // ================================================
   // Write port
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < `NANORV_NREGS; i++) begin
            regs[i] <= `NANORV_REG_RESET;
         end
      end else if (wr.valid && (wr.rd != '0)) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // ================================================
   // Read ports
   // ================================================
   always_comb begin
      rs1_data = '0;
      rs2_data = '0;
      if (rs1_idx != '0) begin
         rs1_data = regs[rs1_idx];
      end
      if (rs2_idx != '0) begin
         rs2_data = regs[rs2_idx];
      end
   end

   // Destination index must be known whenever a write is requested
   a_wr_rd_known : assert property (@(posedge clk) disable iff (!rst_n)
      wr.valid |-> !$isunknown(wr.rd))
      else $error("regfile write with unknown rd");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the nanorv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_nanorv_core \
   -f nanorv_core.f -o sim_nanorv_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_nanorv_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
   exit 0
fi
exit 1

// File: tb_nanorv_checker.sv
// Checker: RV32I reference function, shadow registers and write-back comparison
`timescale 1ns/1ps
`default_nettype none

`include "nanorv_consts.svh"

module tb_nanorv_checker (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    inst_valid,
   input  wire logic [`NANORV_XLEN-1:0] inst,
   input  wire logic [`NANORV_XLEN-1:0] pc,
   input  nanorv_pkg::wb_t              wb,
   input  wire logic                    illegal_instruction,
   output int                           error_count,
   output int                           check_count
);

   typedef struct packed {
      logic                      valid;
      logic [`NANORV_REG_AW-1:0] rd;
      logic [`NANORV_XLEN-1:0]   data;
      logic                      illegal;
   } expect_t;

   logic [`NANORV_XLEN-1:0] shadow [`NANORV_NREGS];
   expect_t                 next_exp;
   expect_t                 exp_q;
   logic                    pending;
   int                      err_cnt = 0;
   int                      chk_cnt = 0;

   // ================================================
   // Reference model
   // ================================================
   function automatic expect_t ref_exec(input logic [31:0] w, input logic [31:0] pc_v,
                                        input logic [31:0] regs [`NANORV_NREGS]);
      expect_t     r;
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  sh;
      logic        is_op;
      logic        alt;
      logic        ok;
      is_op  = (w[6:0] == `NANORV_OPC_OP);
      alt    = (w[31:25] == 7'h20);
      a      = regs[w[19:15]];
      // OP-IMM uses the sign-extended I immediate, its low 5 bits are the shamt
      b      = is_op ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
      sh     = b[4:0];
      ok     = 1'b1;
      r.data = '0;
      case (w[6:0])
         `NANORV_OPC_OP_IMM, `NANORV_OPC_OP: begin
            // OP and immediate shifts need funct7 zero, or alt for SUB, SRA, SRAI
            if (is_op || w[13:12] == 2'b01) begin
               ok = (w[31:25] == 7'h00) ||
                    (alt && (w[14:12] == 3'd5 || (w[14:12] == 3'd0 && is_op)));
            end
            case (w[14:12])
               3'd0: r.data = (alt && is_op) ? a - b : a + b;
               3'd1: r.data = a << sh;
               3'd2: r.data = {31'b0, $signed(a) < $signed(b)};
               3'd3: r.data = {31'b0, a < b};
               3'd4: r.data = a ^ b;
               3'd5: r.data = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
               3'd6: r.data = a | b;
               3'd7: r.data = a & b;
            endcase
         end
         `NANORV_OPC_LUI:   r.data = {w[31:12], 12'b0};
         `NANORV_OPC_AUIPC: r.data = pc_v + {w[31:12], 12'b0};
         default:           ok = 1'b0;
      endcase
      r.valid   = ok;
      r.illegal = !ok;
      r.rd      = w[11:7];
      return r;
   endfunction

   always_comb begin
      if (inst_valid) begin
         next_exp = ref_exec(inst, pc, shadow);
      end else begin
         next_exp = '0;
      end
   end

   // Sample each input word and update the shadow registers, x0 stays zero
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NANORV_NREGS; i++) begin
            shadow[i] <= '0;
         end
         exp_q   <= '0;
         pending <= 1'b0;
      end else begin
         exp_q   <= next_exp;
         pending <= 1'b1;
         if (next_exp.valid && next_exp.rd != 5'd0) begin
            shadow[next_exp.rd] <= next_exp.data;
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] expv,
                              input logic [31:0] got);
      chk_cnt++;
      if (got !== expv) begin
         err_cnt++;
         $display("error t=%0t %s expected %h got %h", $time, name, expv, got);
      end
   endtask

   // ================================================
   // Compare registered outputs at mid cycle
   // ================================================
   always @(negedge clk) begin
      if (!rst_n || pending) begin
         check_value("wb.valid", 32'(exp_q.valid), 32'(wb.valid));
         check_value("illegal_instruction", 32'(exp_q.illegal), 32'(illegal_instruction));
         if (exp_q.valid) begin
            check_value("wb.rd", 32'(exp_q.rd), 32'(wb.rd));
            check_value("wb.data", exp_q.data, wb.data);
         end
      end
   end

   assign error_count = err_cnt;
   assign check_count = chk_cnt;

endmodule

`default_nettype wire

// File: tb_nanorv_core.sv
// Testbench top: clock, reset, random and directed stimulus, watchdog, UUT and checker
`timescale 1ns/1ps
`default_nettype none

`include "nanorv_consts.svh"

module tb_nanorv_core;

   localparam int CLK_PERIOD = 40;
   localparam int N_RANDOM   = 200;
   localparam int N_ILLEGAL  = 40;
   // Register fill, random, illegal pairs, then directed cycles and slack
   localparam int N_CYCLES   = 62 + N_RANDOM + 2 * N_ILLEGAL + 100;

   logic                    clk;
   logic                    rst_n;
   logic                    inst_valid;
   logic [`NANORV_XLEN-1:0] inst;
   logic [`NANORV_XLEN-1:0] pc;
   nanorv_pkg::wb_t         wb;
   logic                    illegal_instruction;
   int                      error_count;
   int                      check_count;
   logic [31:0]             rnd;
   logic [31:0]             rnd2;
   logic [31:0]             word;
   logic [4:0]              rs1;
   logic [4:0]              last_rd;
   logic [6:0]              f7;

   nanorv_core UUT (
      .clk                 (clk),
      .rst_n               (rst_n),
      .inst_valid          (inst_valid),
      .inst                (inst),
      .pc                  (pc),
      .wb                  (wb),
      .illegal_instruction (illegal_instruction)
   );

   tb_nanorv_checker u_checker (
      .clk                 (clk),
      .rst_n               (rst_n),
      .inst_valid          (inst_valid),
      .inst                (inst),
      .pc                  (pc),
      .wb                  (wb),
      .illegal_instruction (illegal_instruction),
      .error_count         (error_count),
      .check_count         (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(N_CYCLES * CLK_PERIOD);
      $display("Timeout: stimulus did not finish within %0d cycles", N_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   // ================================================
   // Stimulus helpers
   // ================================================
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] r_word(input logic [6:0] fn7, input logic [4:0] rs2_f,
                                          input logic [4:0] rs1_f, input logic [2:0] fn3,
                                          input logic [4:0] rd_f);
      return {fn7, rs2_f, rs1_f, fn3, rd_f, `NANORV_OPC_OP};
   endfunction

   function automatic logic [31:0] i_word(input logic [11:0] imm12, input logic [4:0] rs1_f,
                                          input logic [2:0] fn3, input logic [4:0] rd_f);
      return {imm12, rs1_f, fn3, rd_f, `NANORV_OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [19:0] imm20,
                                          input logic [4:0] rd_f);
      return {imm20, rd_f, opc};
   endfunction

   task automatic issue_inst(input logic [31:0] w, input logic [31:0] pc_v);
      @(negedge clk);
      inst_valid = 1'b1;
      inst       = w;
      pc         = pc_v;
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      inst_valid = 1'b0;
   endtask

   // ================================================
   // Test sequence
   // ================================================
   initial begin
      rst_n      = 1'b0;
      inst_valid = 1'b0;
      inst       = '0;
      pc         = '0;
      rnd        = 32'd34190;
      last_rd    = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Fresh registers read as zero
      issue_inst(r_word(`NANORV_F7_BASE, 5'd7, 5'd3, `NANORV_F3_ADD, 5'd5), '0);
      issue_inst(r_word(`NANORV_F7_BASE, 5'd1, 5'd31, `NANORV_F3_ADD, 5'd6), '0);

      // LUI then a dependent ADDI into every register
      for (int i = 1; i < `NANORV_NREGS; i++) begin
         rnd = xorshift32(rnd);
         issue_inst(u_word(`NANORV_OPC_LUI, rnd[31:12], 5'(i)), '0);
         issue_inst(i_word(rnd[11:0], 5'(i), `NANORV_F3_ADD, 5'(i)), '0);
      end

      // Back to back OP and OP-IMM, about half reading the previous rd
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd2 = xorshift32(rnd);
         rnd  = xorshift32(rnd2);
         rs1  = rnd2[12] ? last_rd : rnd2[17:13];
         f7   = (rnd2[23] && (rnd2[2:0] == `NANORV_F3_ADD || rnd2[2:0] == `NANORV_F3_SR)) ?
                `NANORV_F7_ALT : `NANORV_F7_BASE;
         if (rnd2[24]) begin
            issue_inst(r_word(f7, rnd2[22:18], rs1, rnd2[2:0], rnd2[7:3]), '0);
         end else if (rnd2[1:0] == 2'b01) begin
            issue_inst(i_word({f7, rnd[4:0]}, rs1, rnd2[2:0], rnd2[7:3]), '0);
         end else begin
            issue_inst(i_word(rnd[11:0], rs1, rnd2[2:0], rnd2[7:3]), '0);
         end
         last_rd = rnd2[7:3];
      end

      // Sign bit corner cases: x1 = 0x80000005, x2 = -3
      issue_inst(u_word(`NANORV_OPC_LUI, 20'h80000, 5'd1), '0);
      issue_inst(i_word(12'h005, 5'd1, `NANORV_F3_ADD, 5'd1), '0);
      issue_inst(i_word(12'hffd, 5'd0, `NANORV_F3_ADD, 5'd2), '0);
      issue_inst(r_word(`NANORV_F7_ALT, 5'd1, 5'd2, `NANORV_F3_ADD, 5'd3), '0);
      issue_inst(r_word(`NANORV_F7_ALT, 5'd2, 5'd1, `NANORV_F3_SR, 5'd4), '0);
      issue_inst(r_word(`NANORV_F7_BASE, 5'd2, 5'd1, `NANORV_F3_SR, 5'd11), '0);
      issue_inst(i_word({`NANORV_F7_ALT, 5'd4}, 5'd1, `NANORV_F3_SR, 5'd5), '0);
      issue_inst(r_word(`NANORV_F7_BASE, 5'd2, 5'd1, `NANORV_F3_SLT, 5'd6), '0);
      issue_inst(r_word(`NANORV_F7_BASE, 5'd2, 5'd1, `NANORV_F3_SLTU, 5'd7), '0);
      issue_inst(r_word(`NANORV_F7_BASE, 5'd1, 5'd2, `NANORV_F3_SLT, 5'd8), '0);
      // Negative x1 against +1, signed and unsigned answers differ
      issue_inst(i_word(12'h001, 5'd1, `NANORV_F3_SLT, 5'd9), '0);
      issue_inst(i_word(12'h001, 5'd1, `NANORV_F3_SLTU, 5'd10), '0);

      // LUI and AUIPC against random word aligned PCs
      for (int k = 0; k < 8; k++) begin
         rnd = xorshift32(rnd);
         issue_inst(u_word(`NANORV_OPC_LUI, rnd[31:12], 5'd14), '0);
         issue_inst(u_word(`NANORV_OPC_AUIPC, rnd[19:0], 5'd15), {rnd[29:0], 2'b00});
      end

      // Write to x0 is reported, x0 still reads zero
      issue_inst(i_word(12'h123, 5'd1, `NANORV_F3_ADD, 5'd0), '0);
      issue_inst(r_word(`NANORV_F7_BASE, 5'd0, 5'd0, `NANORV_F3_ADD, 5'd12), '0);

      // Illegal words, each followed by a read of its rd
      for (int n = 0; n < N_ILLEGAL; n++) begin
         rnd2 = xorshift32(rnd);
         rnd  = xorshift32(rnd2);
         case (n % 3)
            0: begin
               word = rnd;
               if (word[6:0] == `NANORV_OPC_OP_IMM || word[6:0] == `NANORV_OPC_OP ||
                   word[6:0] == `NANORV_OPC_LUI || word[6:0] == `NANORV_OPC_AUIPC) begin
                  word[6] = 1'b1;
               end
            end
            // funct7 bit 0 set is neither base nor alt
            1: word = r_word({rnd2[6:1], 1'b1}, rnd2[11:7], rnd2[16:12], rnd2[19:17],
                             rnd2[24:20]);
            default: word = i_word({`NANORV_F7_ALT, rnd2[4:0]}, rnd2[9:5], `NANORV_F3_SLL,
                                   rnd2[14:10]);
         endcase
         issue_inst(word, rnd2);
         issue_inst(r_word(`NANORV_F7_BASE, 5'd0, word[11:7], `NANORV_F3_ADD, 5'd16), '0);
      end

      idle_cycle();
      idle_cycle();
      @(negedge clk);
      #1;
      $display("Checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
